//--- project.f
common/flow_pkg.sv
common/flit_if.sv
common/word_if.sv
verilog/flit_skid.sv
flow_deser/flow_deser.sv
verilog/word_fifo.sv
verilog/flow_deser_top.sv
verif/tb_flow_deser.sv

//--- verif/tb_flow_deser.sv
//////////////////////////////
// Testbench for the flit to word
// deserializing link
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module tb_flow_deser;
  import flow_pkg::*;

  // One expected word as the model sees it
  typedef struct packed {
    word_data_t data;
    logic       last;
    cnt_t       cnt;
    meta_t      meta;
  } exp_word_t;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  flit_data_t in_data;
  logic       in_last;
  meta_t      in_metadata;
  logic       out_valid;
  logic       out_ready;
  word_data_t out_data;
  logic       out_last;
  cnt_t       out_dont_care_count;
  meta_t      out_metadata;

  logic [31:0] lfsr = 32'hcdc;
  exp_word_t   exp_q[$];
  int          len_q[$];
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        ready_random = 1'b0;
  logic        input_gaps = 1'b0;

  // Number of words that each of tests 2 to 5 sends
  // Test 1 only checks the reset state
  int test_words [2:5] = '{24, 24, 40, 40};

  // Output payload seen at a stalled edge is checked on the next edge
  logic      stall_seen = 1'b0;
  exp_word_t held;
  exp_word_t head;

  flow_deser_top DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .in_valid            (in_valid),
    .in_ready            (in_ready),
    .in_data             (in_data),
    .in_last             (in_last),
    .in_metadata         (in_metadata),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .out_data            (out_data),
    .out_last            (out_last),
    .out_dont_care_count (out_dont_care_count),
    .out_metadata        (out_metadata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit handed out
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Only the lanes that hold real flits are compared
  task automatic check_word(input word_data_t got, input word_data_t exp,
                            input cnt_t dc, input string what);
    int   i;
    logic bad;
    bad = 1'b0;
    checks++;
    for (i = 0; i < RATIO - int'(dc); i++) begin
      if (got[(RATIO-1-i)*PUSH_WIDTH +: PUSH_WIDTH] !==
          exp[(RATIO-1-i)*PUSH_WIDTH +: PUSH_WIDTH]) begin
        bad = 1'b1;
      end
    end
    if (bad) begin
      errors++;
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_count(input cnt_t got, input cnt_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic match_meta(input meta_t got, input meta_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic expect_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Called once per falling edge
  // In random mode about half the cycles stall
  task automatic drive_ready();
    logic [31:0] r;
    out_ready = 1'b1;
    if (ready_random) begin
      take_bits(1, r);
      out_ready = r[0];
    end
  endtask

  // Valid stays up with the same payload until the flit is taken
  task automatic send_flit(input flit_data_t d, input logic l, input meta_t m);
    logic [31:0] r;
    r = '0;
    if (input_gaps) begin
      take_bits(2, r);
    end
    repeat (r[1:0]) begin
      @(negedge clk);
      drive_ready();
      in_valid = 1'b0;
    end
    @(negedge clk);
    drive_ready();
    in_valid    = 1'b1;
    in_data     = d;
    in_last     = l;
    in_metadata = m;
    // in_ready is registered, so this value also holds at the next rising edge
    while (!in_ready) begin
      @(negedge clk);
      drive_ready();
    end
  endtask

  task automatic send_word(input int len, input logic last_on_full);
    logic [31:0] r;
    flit_data_t  fl [RATIO];
    meta_t       meta;
    logic        last_bit;
    exp_word_t   e;
    take_bits(META_WIDTH, r);
    meta = meta_t'(r);
    // Short words always end with last, full words only sometimes
    last_bit = (len < RATIO);
    if (len == RATIO && last_on_full) begin
      take_bits(1, r);
      last_bit = r[0];
    end
    e.data = '0;
    for (int i = 0; i < len; i++) begin
      take_bits(PUSH_WIDTH, r);
      fl[i] = flit_data_t'(r);
      // First flit goes to the top byte, later ones step down
      e.data[(RATIO-1-i)*PUSH_WIDTH +: PUSH_WIDTH] = fl[i];
    end
    e.last = last_bit;
    e.cnt  = cnt_t'(RATIO - len);
    e.meta = meta;
    exp_q.push_back(e);
    for (int i = 0; i < len; i++) begin
      send_flit(fl[i], last_bit && (i == len - 1), meta);
    end
  endtask

  // Kind 0 gives full words, kind 1 short words, kind 2 any length
  task automatic pick_len(input int kind, output int len);
    logic [31:0] r;
    len = RATIO;
    if (kind == 1) begin
      take_bits(2, r);
      len = int'(r % 3) + 1;
    end else if (kind == 2) begin
      take_bits(2, r);
      len = int'(r) + 1;
    end
  endtask

  task automatic run_test(input int t, input string name);
    int len;
    int err0;
    err0 = errors;
    ready_random = (t >= 4);
    input_gaps   = (t == 5);
    repeat (test_words[t]) begin
      len = len_q.pop_front();
      send_word(len, t >= 4);
    end
    @(negedge clk);
    in_valid = 1'b0;
    drive_ready();
    // Drain until every modelled word has come out
    while (exp_q.size() != 0) begin
      @(negedge clk);
      drive_ready();
    end
    $display("test %0d %s done: %0d words, %0d errors", t, name, test_words[t],
             errors - err0);
  endtask

  // Output side of the model pops one word per transfer
  always @(posedge clk) begin
    if (rst_n) begin
      if (stall_seen) begin
        if (!out_valid) begin
          errors++;
          $display("out_valid dropped at %0t ns while a word was stalled", $time);
        end else begin
          check_word(out_data, held.data, '0, "stalled data");
          compare_count(out_dont_care_count, held.cnt, "stalled count");
          match_meta(out_metadata, held.meta, "stalled metadata");
          expect_bit(out_last, held.last, "stalled last");
        end
      end
      stall_seen = out_valid && !out_ready;
      held = {out_data, out_last, out_dont_care_count, out_metadata};
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a word came out at %0t ns when none was expected", $time);
        end else begin
          head = exp_q.pop_front();
          check_word(out_data, head.data, head.cnt, "word data");
          compare_count(out_dont_care_count, head.cnt, "don't-care count");
          match_meta(out_metadata, head.meta, "word metadata");
          expect_bit(out_last, head.last, "word last");
        end
      end
    end
  end

  // Watchdog against a stuck handshake
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("run timed out after %0d cycles with %0d words still expected",
               cycle_count, exp_q.size());
      $display("deserializer was in %s when the run stopped",
               (DUT.u_deser.state == DESER_HOLD) ? "DESER_HOLD" : "DESER_FILL");
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int len;
    int total;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    in_last     = 1'b0;
    in_metadata = '0;
    out_ready   = 1'b0;
    total       = 0;
    // Word lengths are drawn up front so the watchdog knows the flit count
    for (int t = 2; t <= 5; t++) begin
      for (int w = 0; w < test_words[t]; w++) begin
        pick_len((t == 2) ? 0 : (t == 3) ? 1 : 2, len);
        len_q.push_back(len);
        total += len;
      end
    end
    cycle_limit = 8 * total + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    out_ready = 1'b1;
    repeat (3) begin
      @(negedge clk);
      expect_bit(out_valid, 1'b0, "out_valid after reset");
      expect_bit(in_ready, 1'b1, "in_ready after reset");
    end
    $display("test 1 reset state done: %0d errors", errors);
    run_test(2, "full words");
    run_test(3, "short words");
    run_test(4, "back-pressure");
    run_test(5, "bursty input");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_flow_deser

`default_nettype wire

//--- verilog/flow_deser_top.sv
//////////////////////////////
// Deserializing link top level
// skid -> deserializer -> FIFO
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module flow_deser_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Narrow flit input
  input  logic                 in_valid,
  output logic                 in_ready,
  input  flow_pkg::flit_data_t in_data,
  input  logic                 in_last,
  input  flow_pkg::meta_t      in_metadata,

  // Wide word output
  output logic                 out_valid,
  input  logic                 out_ready,
  output flow_pkg::word_data_t out_data,
  output logic                 out_last,
  output flow_pkg::cnt_t       out_dont_care_count,
  output flow_pkg::meta_t      out_metadata
);

  // Channels between the pins and the three stages
  flit_if in_flit ();
  flit_if skid_flit ();
  word_if deser_word ();
  word_if out_word ();

  // Input pins into the skid channel
  assign in_flit.valid    = in_valid;
  assign in_flit.data     = in_data;
  assign in_flit.last     = in_last;
  assign in_flit.metadata = in_metadata;
  assign in_ready         = in_flit.ready;

  flit_skid u_skid (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (in_flit),
    .down  (skid_flit)
  );

  flow_deser u_deser (
    .clk   (clk),
    .rst_n (rst_n),
    .flits (skid_flit),
    .words (deser_word)
  );

  word_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (deser_word),
    .rd    (out_word)
  );

  // FIFO read side out to the pins
  assign out_word.ready      = out_ready;
  assign out_valid           = out_word.valid;
  assign out_data            = out_word.data;
  assign out_last            = out_word.last;
  assign out_dont_care_count = out_word.dont_care_count;
  assign out_metadata        = out_word.metadata;

endmodule : flow_deser_top

`default_nettype wire

//--- verilog/word_fifo.sv
//////////////////////////////
// Word FIFO, four entries,
// first-word-fall-through read
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module word_fifo (
  input  logic     clk,
  input  logic     rst_n,
  word_if.receiver wr,
  word_if.sender   rd
);
  import flow_pkg::*;

  // Storage, one slot per word field
  word_data_t mem_data [FIFO_DEPTH];
  logic       mem_last [FIFO_DEPTH];
  cnt_t       mem_cnt  [FIFO_DEPTH];
  meta_t      mem_meta [FIFO_DEPTH];

  // Pointers wrap on their own because the depth is a power of two
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);

  // When full, a read in the same cycle frees the slot for the write
  assign wr.ready = ~full | rd.ready;
  assign rd.valid = ~empty;

  assign push = wr.valid & wr.ready;
  assign pop  = rd.valid & rd.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entries are written in place, nothing else touches them
  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= wr.data;
      mem_last[wr_ptr] <= wr.last;
      mem_cnt[wr_ptr]  <= wr.dont_care_count;
      mem_meta[wr_ptr] <= wr.metadata;
    end
  end

  // Head entry shows up directly on the read side
  assign rd.data            = mem_data[rd_ptr];
  assign rd.last            = mem_last[rd_ptr];
  assign rd.dont_care_count = mem_cnt[rd_ptr];
  assign rd.metadata        = mem_meta[rd_ptr];

endmodule : word_fifo

`default_nettype wire

//--- flow_deser/flow_deser.sv
//////////////////////////////
// Flit to word deserializer
// Packs four flits MSB first and
// reports unused trailing lanes
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module flow_deser (
  input  logic     clk,
  input  logic     rst_n,
  flit_if.receiver flits,
  word_if.sender   words
);
  import flow_pkg::*;

  // FSM state, DESER_HOLD while the output register is occupied
  deser_state_t state;

  // Index of the next flit inside the word being assembled
  cnt_t idx;

  // Assembly register and the metadata of the word's first flit
  word_data_t asm_data;
  meta_t      asm_meta;

  // Assembly contents with the current flit merged in
  word_data_t asm_next;
  meta_t      meta_next;

  // Lane that the current flit lands in
  cnt_t lane;

  // Registered word output
  word_data_t out_data;
  logic       out_last;
  cnt_t       out_cnt;
  meta_t      out_meta;

  logic is_final;
  logic accept;
  logic complete;
  logic take;

  // A flit closes the word at the last lane or when it carries last
  assign is_final = (idx == cnt_t'(RATIO - 1)) | flits.last;

  // The held word leaves in this cycle
  assign take = (state == DESER_HOLD) & words.ready;

  // Non-final flits are always welcome since they only touch the
  // assembly register
  // A final flit needs a free output register, either empty or
  // being emptied in this very cycle
  assign flits.ready = ~is_final | (state == DESER_FILL) | words.ready;

  assign accept   = flits.valid & flits.ready;
  assign complete = accept & is_final;

  // Lane RATIO-1-idx puts the first flit in the top bits
  // The same value is the don't-care count when this flit ends the word
  assign lane = cnt_t'(RATIO - 1) - idx;

  always_comb begin
    asm_next = asm_data;
    asm_next[lane*PUSH_WIDTH +: PUSH_WIDTH] = flits.data;
    // Metadata is taken from the first flit of every word
    meta_next = (idx == '0) ? flits.metadata : asm_meta;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DESER_FILL;
      idx   <= '0;
    end else begin
      if (complete) begin
        // Output register gets refilled, so stay or go to hold
        state <= DESER_HOLD;
        idx   <= '0;
      end else begin
        if (accept) begin
          idx <= idx + 1'b1;
        end
        if (take) begin
          state <= DESER_FILL;
        end
      end
    end
  end

  // Lanes past the last flit keep stale bytes from earlier words
  always_ff @(posedge clk) begin
    if (accept) begin
      asm_data <= asm_next;
      asm_meta <= meta_next;
    end
    if (complete) begin
      out_data <= asm_next;
      out_last <= flits.last;
      out_cnt  <= lane;
      out_meta <= meta_next;
    end
  end

  assign words.valid           = (state == DESER_HOLD);
  assign words.data            = out_data;
  assign words.last            = out_last;
  assign words.dont_care_count = out_cnt;
  assign words.metadata        = out_meta;

endmodule : flow_deser

`default_nettype wire

//--- verilog/flit_skid.sv
//////////////////////////////
// Ingress skid buffer, main and
// spill register, registered ready
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module flit_skid (
  input  logic     clk,
  input  logic     rst_n,
  flit_if.receiver up,
  flit_if.sender   down
);
  import flow_pkg::*;

  // Main register feeds the output directly
  logic       main_valid;
  flit_data_t main_data;
  logic       main_last;
  meta_t      main_meta;

  // Spill register catches the flit that arrives during a stall
  logic       spill_valid;
  flit_data_t spill_data;
  logic       spill_last;
  meta_t      spill_meta;

  logic accept;
  logic drain;
  logic load_main_up;
  logic load_main_spill;
  logic load_spill;

  // Ready only looks at occupancy, so no path from down.ready to up.ready
  // It drops only once both registers hold a flit
  assign up.ready = ~spill_valid;

  assign accept = up.valid & ~spill_valid;
  assign drain  = main_valid & down.ready;

  // A waiting spill flit always moves up first to keep the order
  assign load_main_spill = spill_valid & drain;
  // New flit goes straight to main when main is free or being emptied
  assign load_main_up    = accept & (~main_valid | drain);
  // Otherwise it has to park in the spill register
  assign load_spill      = accept & main_valid & ~drain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid  <= 1'b0;
      spill_valid <= 1'b0;
    end else begin
      if (load_main_up || load_main_spill) begin
        main_valid <= 1'b1;
      end else if (drain) begin
        main_valid <= 1'b0;
      end
      if (load_spill) begin
        spill_valid <= 1'b1;
      end else if (load_main_spill) begin
        spill_valid <= 1'b0;
      end
    end
  end

  // Payload registers only follow the load strobes
  always_ff @(posedge clk) begin
    if (load_main_spill) begin
      main_data <= spill_data;
      main_last <= spill_last;
      main_meta <= spill_meta;
    end else if (load_main_up) begin
      main_data <= up.data;
      main_last <= up.last;
      main_meta <= up.metadata;
    end
    if (load_spill) begin
      spill_data <= up.data;
      spill_last <= up.last;
      spill_meta <= up.metadata;
    end
  end

  assign down.valid    = main_valid;
  assign down.data     = main_data;
  assign down.last     = main_last;
  assign down.metadata = main_meta;

endmodule : flit_skid

`default_nettype wire

//--- common/word_if.sv
//////////////////////////////
// Wide word channel
// valid/ready with last, count
// of unused lanes and metadata
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

interface word_if;
  import flow_pkg::*;

  // Handshake pair, same transfer rule as the flit channel
  logic       valid;
  logic       ready;

  // Word payload with the first flit in the top lane
  word_data_t data;
  logic       last;

  // Number of trailing lanes that carry stale data
  // Always zero unless last is set
  cnt_t       dont_care_count;
  meta_t      metadata;

  // Producer of words
  modport sender (
    output valid,
    output data,
    output last,
    output dont_care_count,
    output metadata,
    input  ready
  );

  // Consumer of words
  modport receiver (
    input  valid,
    input  data,
    input  last,
    input  dont_care_count,
    input  metadata,
    output ready
  );

endinterface : word_if

`default_nettype wire

//--- common/flit_if.sv
//////////////////////////////
// Narrow flit channel
// valid/ready with last and meta
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

interface flit_if;
  import flow_pkg::*;

  // Handshake pair, a transfer happens when both are high at clk
  logic       valid;
  logic       ready;

  // Payload, held stable by the sender until it is taken
  flit_data_t data;
  logic       last;
  meta_t      metadata;

  // Source side drives everything except ready
  modport sender (
    output valid,
    output data,
    output last,
    output metadata,
    input  ready
  );

  // Sink side only answers with ready
  modport receiver (
    input  valid,
    input  data,
    input  last,
    input  metadata,
    output ready
  );

endinterface : flit_if

`default_nettype wire

//--- common/flow_pkg.sv
//////////////////////////////
// Flow deserializer package
// Widths, word types and the
// deserializer state encoding
//////////////////////////////

`default_nettype none

package flow_pkg;

  // Narrow flit width on the ingress side
  localparam int PUSH_WIDTH = 8;

  // Assembled word width on the egress side
  localparam int POP_WIDTH = 32;

  // Sideband metadata travels next to the payload and is never packed
  localparam int META_WIDTH = 3;

  // Flits per word, four lanes of one byte each
  localparam int RATIO = POP_WIDTH / PUSH_WIDTH;

  // Holds a flit index 0..RATIO-1 and the don't-care count
  localparam int CNT_WIDTH = $clog2(RATIO);

  // Number of finished words the egress FIFO can hold
  localparam int FIFO_DEPTH = 4;

  // One flit of payload
  typedef logic [PUSH_WIDTH-1:0] flit_data_t;

  // One assembled word, first flit in the top lane
  typedef logic [POP_WIDTH-1:0] word_data_t;

  // Sideband metadata of a flit or a word
  typedef logic [META_WIDTH-1:0] meta_t;

  // Flit index inside a word, also used for the unused lane count
  typedef logic [CNT_WIDTH-1:0] cnt_t;

  // Deserializer states
  // DESER_HOLD means a finished word sits in the output register
  // and waits for the downstream ready
  typedef enum logic {
    DESER_FILL = 1'b0,
    DESER_HOLD = 1'b1
  } deser_state_t;

endpackage : flow_pkg

`default_nettype wire
